// ==== hdl/immu_pkg.sv ====
/*
 * Shared constants and entry layouts of the instruction TLB.
 * Pages are 8 KB; only the 32-bit address space is supported.
 * The ITLB lives in SPR group 2, at most four ways are addressable.
 */
package immu_pkg;

   // Datapath and page geometry
   localparam int DATA_W    = 32;
   localparam int PAGE_BITS = 13;
   localparam int VPN_W     = DATA_W - PAGE_BITS;

   // SPR address map
   localparam int SPR_ADDR_W = 16;
   localparam logic [4:0] SPR_GROUP_IMMU = 5'd2;

   // Way index is {addr[10], addr[8]}, so four ways at most
   localparam int MAX_WAYS = 4;

   typedef logic [SPR_ADDR_W-1:0] spr_addr_t;

   // ITLBWxMR layout
   typedef struct packed {
      logic [VPN_W-1:0] vpn;
      logic [10:0]      rsvd;
      logic             pl1;
      logic             valid;
   } match_entry_t;

   // ITLBWxTR layout
   typedef struct packed {
      logic [VPN_W-1:0] ppn;
      logic [4:0]       rsvd;
      logic             uxe;
      logic             sxe;
      logic             d;
      logic             a;
      logic             wom;
      logic             wbc;
      logic             ci;
      logic             cc;
   } trans_entry_t;

   // One SPR or RAM word, read as match or translate entry
   typedef union packed {
      match_entry_t m;
      trans_entry_t t;
   } itlb_entry_u;

endpackage

// ==== hdl/immu_spr_decode.sv ====
/*
 * SPR decoder of the ITLB, group 2 only.
 * The master must hold strobe, address and data until acknowledge,
 * and drop strobe for a cycle between group-2 accesses.
 * Way index above NUM_WAYS is truncated to the implemented ways.
 */
module immu_spr_decode #(
   parameter int NUM_WAYS  = 2,
   parameter int SET_WIDTH = 6
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   enable_i,
   input  immu_pkg::spr_addr_t    spr_addr_i,
   input  logic                   spr_we_i,
   input  logic                   spr_stb_i,
   input  immu_pkg::itlb_entry_u  spr_dat_i,
   input  logic [31:0]            virt_addr_i,
   output logic [SET_WIDTH-1:0]   ram_addr_o,
   output immu_pkg::itlb_entry_u  wdata_o,
   output logic                   match_we_o [NUM_WAYS],
   output logic                   trans_we_o [NUM_WAYS],
   output logic                   rd_match_sel_o,
   output logic                   rd_trans_sel_o,
   output logic [1:0]             rd_way_o,
   output logic                   spr_ack_o,
   output logic                   busy_o
);
   import immu_pkg::*;

   localparam int WAY_W = (NUM_WAYS < 2) ? 1 : $clog2(NUM_WAYS);

   logic             grp_hit;
   logic             tlb_hit;
   logic             match_cs;
   logic             trans_cs;
   logic             match_cs_q;
   logic             trans_cs_q;
   logic             match_tx;
   logic             trans_tx;
   logic             tx_q;
   logic             ack_q;
   logic [1:0]       way_full;
   logic [WAY_W-1:0] way_idx;
   logic [1:0]       way_q;
   logic [NUM_WAYS-1:0] match_we;
   logic [NUM_WAYS-1:0] trans_we;

   assign grp_hit = spr_addr_i[15:11] == SPR_GROUP_IMMU;
   // Bits 10:9 both zero are control and status, not TLB entries
   assign tlb_hit = grp_hit & (|spr_addr_i[10:9]);

   assign match_cs = spr_stb_i & tlb_hit & ~spr_addr_i[7];
   assign trans_cs = spr_stb_i & tlb_hit & spr_addr_i[7];

   // Start of a transaction is the first cycle of chip select
   assign match_tx = match_cs & ~match_cs_q;
   assign trans_tx = trans_cs & ~trans_cs_q;

   assign way_full = {spr_addr_i[10], spr_addr_i[8]};
   assign way_idx  = way_full[WAY_W-1:0];

   always_ff @(posedge clk) begin
      if (rst) begin
         match_cs_q <= 1'b0;
         trans_cs_q <= 1'b0;
         tx_q       <= 1'b0;
         ack_q      <= 1'b0;
         way_q      <= 2'd0;
      end else begin
         match_cs_q <= match_cs;
         trans_cs_q <= trans_cs;
         tx_q       <= match_tx | trans_tx;
         ack_q      <= spr_stb_i & grp_hit;
         way_q      <= 2'(way_idx);
      end
   end

   // SPR set only during the start pulse, else the fetch page index
   assign ram_addr_o = (match_tx | trans_tx) ? spr_addr_i[SET_WIDTH-1:0] :
                       virt_addr_i[PAGE_BITS +: SET_WIDTH];
   assign wdata_o    = spr_dat_i;

   for (genvar g = 0; g < NUM_WAYS; g++) begin : g_we
      assign match_we[g]   = match_tx & spr_we_i & (way_idx == WAY_W'(g));
      assign trans_we[g]   = trans_tx & spr_we_i & (way_idx == WAY_W'(g));
      assign match_we_o[g] = match_we[g];
      assign trans_we_o[g] = trans_we[g];
   end

   assign rd_match_sel_o = match_cs_q;
   assign rd_trans_sel_o = trans_cs_q;
   assign rd_way_o       = way_q;

   // Ack drops with the strobe even while the registered copy is high
   assign spr_ack_o = ack_q & spr_stb_i & grp_hit;

   // Lookup results are stale for the start cycle and the next one
   assign busy_o = enable_i & (match_tx | trans_tx | tx_q);

   // Master keeps strobe and address until it sees acknowledge
   a_stb_held: assert property (@(posedge clk) disable iff (rst)
      spr_stb_i && grp_hit && !spr_ack_o |=> spr_stb_i && $stable(spr_addr_i));

   a_we_needs_write: assert property (@(posedge clk) disable iff (rst)
      $rose(|{match_we, trans_we}) |-> spr_we_i && spr_stb_i && !$past(tx_q));

endmodule

// ==== hdl/immu_itlb_way.sv ====
/*
 * One ITLB way: match RAM, translate RAM and the page comparator.
 * RAM contents have no reset; software must write every valid bit.
 * Reads are synchronous and write-first.
 */
module immu_itlb_way #(
   parameter int NUM_WAYS  = 2,
   parameter int SET_WIDTH = 6
) (
   input  logic                   clk,
   input  logic [SET_WIDTH-1:0]   ram_addr_i,
   input  immu_pkg::itlb_entry_u  wdata_i,
   input  logic                   match_we_i,
   input  logic                   trans_we_i,
   input  logic [31:0]            virt_addr_match_i,
   output immu_pkg::itlb_entry_u  match_o,
   output immu_pkg::itlb_entry_u  trans_o,
   output logic                   hit_o
);
   import immu_pkg::*;

   localparam int SETS = 2 ** SET_WIDTH;

   itlb_entry_u match_mem [SETS];
   itlb_entry_u trans_mem [SETS];
   itlb_entry_u match_q;
   itlb_entry_u trans_q;

   // The way index field only reaches four ways
   if (NUM_WAYS < 1 || NUM_WAYS > MAX_WAYS) begin : g_bad_ways
      $error("ITLB way count out of range");
   end

   // Match RAM
   always_ff @(posedge clk) begin
      if (match_we_i) begin
         match_mem[ram_addr_i] <= wdata_i;
         match_q               <= wdata_i;
      end else begin
         match_q <= match_mem[ram_addr_i];
      end
   end

   // Translate RAM
   always_ff @(posedge clk) begin
      if (trans_we_i) begin
         trans_mem[ram_addr_i] <= wdata_i;
         trans_q               <= wdata_i;
      end else begin
         trans_q <= trans_mem[ram_addr_i];
      end
   end

   assign match_o = match_q;
   assign trans_o = trans_q;

   // Compare against the address of the next cycle, the RAM
   // was indexed with the previous one
   assign hit_o = match_q.m.valid &
                  (match_q.m.vpn == virt_addr_match_i[DATA_W-1:PAGE_BITS]);

endmodule

// ==== hdl/immu_way_select.sv ====
/*
 * Merges the way results into the translation outputs and SPR read data.
 * At most one way may hit; software keeps VPNs distinct across ways.
 * Miss and page fault are forced low while busy.
 */
module immu_way_select #(
   parameter int NUM_WAYS  = 2,
   parameter int SET_WIDTH = 6
) (
   input  logic                   clk,
   input  logic [31:0]            virt_addr_match_i,
   input  logic                   supervisor_mode_i,
   input  logic                   busy_i,
   input  logic                   hit_i [NUM_WAYS],
   input  immu_pkg::itlb_entry_u  match_i [NUM_WAYS],
   input  immu_pkg::itlb_entry_u  trans_i [NUM_WAYS],
   input  logic                   rd_match_sel_i,
   input  logic                   rd_trans_sel_i,
   input  logic [1:0]             rd_way_i,
   input  logic                   spr_ack_i,
   output logic [31:0]            phys_addr_o,
   output logic                   cache_inhibit_o,
   output logic                   tlb_miss_o,
   output logic                   pagefault_o,
   output logic [31:0]            spr_dat_o
);
   import immu_pkg::*;

   logic [NUM_WAYS-1:0] hit_vec;
   logic                hit_any;
   itlb_entry_u         hit_trans;
   itlb_entry_u         rd_match;
   itlb_entry_u         rd_trans;
   logic [DATA_W-1:0]   rd_data;
   logic [DATA_W-1:0]   rd_data_q;
   logic                exec_ok;
   logic                ack_q;

   for (genvar g = 0; g < NUM_WAYS; g++) begin : g_hit
      assign hit_vec[g] = hit_i[g];
   end

   assign hit_any = |hit_vec;

   // Translate word of the hitting way, all zero on a miss
   always_comb begin
      hit_trans = '0;
      for (int j = 0; j < NUM_WAYS; j++) begin
         if (hit_i[j]) begin
            hit_trans = trans_i[j];
         end
      end
   end

   assign phys_addr_o     = {hit_trans.t.ppn, virt_addr_match_i[PAGE_BITS-1:0]};
   assign cache_inhibit_o = hit_trans.t.ci;

   // A miss leaves both permission bits clear, so it faults too
   assign exec_ok     = supervisor_mode_i ? hit_trans.t.sxe : hit_trans.t.uxe;
   assign tlb_miss_o  = ~hit_any & ~busy_i;
   assign pagefault_o = ~exec_ok & ~busy_i;

   // SPR read mux, ways past NUM_WAYS read as zero
   always_comb begin
      rd_match = '0;
      rd_trans = '0;
      for (int j = 0; j < NUM_WAYS; j++) begin
         if (rd_way_i == 2'(j)) begin
            rd_match = match_i[j];
            rd_trans = trans_i[j];
         end
      end
   end

   assign rd_data = rd_match_sel_i ? rd_match :
                    rd_trans_sel_i ? rd_trans : '0;

   always_ff @(posedge clk) begin
      ack_q <= spr_ack_i;
      if (spr_ack_i & ~ack_q) begin
         rd_data_q <= rd_data;
      end
   end

   // RAM output moves on after the first ack cycle, so hold it
   assign spr_dat_o = (spr_ack_i & ~ack_q) ? rd_data : rd_data_q;

   a_hit_onehot: assert property (@(posedge clk)
      !$isunknown(hit_vec) |-> $onehot0(hit_vec));

endmodule

// ==== hdl/immu_top.sv ====
/*
 * Set-associative instruction TLB, programmed over the SPR bus.
 * No hardware reload: a miss must be served by software.
 * Translation is valid one cycle after virt_addr_i is presented.
 */
module immu_top #(
   parameter int NUM_WAYS  = 2,
   parameter int SET_WIDTH = 6
) (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            enable_i,
   input  logic [immu_pkg::DATA_W-1:0]     virt_addr_i,
   input  logic [immu_pkg::DATA_W-1:0]     virt_addr_match_i,
   input  logic                            supervisor_mode_i,
   input  immu_pkg::spr_addr_t             spr_addr_i,
   input  logic                            spr_we_i,
   input  logic                            spr_stb_i,
   input  logic [immu_pkg::DATA_W-1:0]     spr_dat_i,
   output logic [immu_pkg::DATA_W-1:0]     spr_dat_o,
   output logic                            spr_ack_o,
   output logic [immu_pkg::DATA_W-1:0]     phys_addr_o,
   output logic                            cache_inhibit_o,
   output logic                            tlb_miss_o,
   output logic                            pagefault_o,
   output logic                            busy_o
);
   import immu_pkg::*;

   logic [SET_WIDTH-1:0] ram_addr;
   itlb_entry_u          wdata;
   logic                 match_we [NUM_WAYS];
   logic                 trans_we [NUM_WAYS];
   logic                 rd_match_sel;
   logic                 rd_trans_sel;
   logic [1:0]           rd_way;
   logic                 way_hit [NUM_WAYS];
   itlb_entry_u          way_match [NUM_WAYS];
   itlb_entry_u          way_trans [NUM_WAYS];

   immu_spr_decode #(
      .NUM_WAYS  (NUM_WAYS),
      .SET_WIDTH (SET_WIDTH)
   ) u_decode (
      .clk            (clk),
      .rst            (rst),
      .enable_i       (enable_i),
      .spr_addr_i     (spr_addr_i),
      .spr_we_i       (spr_we_i),
      .spr_stb_i      (spr_stb_i),
      .spr_dat_i      (spr_dat_i),
      .virt_addr_i    (virt_addr_i),
      .ram_addr_o     (ram_addr),
      .wdata_o        (wdata),
      .match_we_o     (match_we),
      .trans_we_o     (trans_we),
      .rd_match_sel_o (rd_match_sel),
      .rd_trans_sel_o (rd_trans_sel),
      .rd_way_o       (rd_way),
      .spr_ack_o      (spr_ack_o),
      .busy_o         (busy_o)
   );

   for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
      immu_itlb_way #(
         .NUM_WAYS  (NUM_WAYS),
         .SET_WIDTH (SET_WIDTH)
      ) u_way (
         .clk               (clk),
         .ram_addr_i        (ram_addr),
         .wdata_i           (wdata),
         .match_we_i        (match_we[g]),
         .trans_we_i        (trans_we[g]),
         .virt_addr_match_i (virt_addr_match_i),
         .match_o           (way_match[g]),
         .trans_o           (way_trans[g]),
         .hit_o             (way_hit[g])
      );
   end

   immu_way_select #(
      .NUM_WAYS  (NUM_WAYS),
      .SET_WIDTH (SET_WIDTH)
   ) u_select (
      .clk               (clk),
      .virt_addr_match_i (virt_addr_match_i),
      .supervisor_mode_i (supervisor_mode_i),
      .busy_i            (busy_o),
      .hit_i             (way_hit),
      .match_i           (way_match),
      .trans_i           (way_trans),
      .rd_match_sel_i    (rd_match_sel),
      .rd_trans_sel_i    (rd_trans_sel),
      .rd_way_i          (rd_way),
      .spr_ack_i         (spr_ack_o),
      .phys_addr_o       (phys_addr_o),
      .cache_inhibit_o   (cache_inhibit_o),
      .tlb_miss_o        (tlb_miss_o),
      .pagefault_o       (pagefault_o),
      .spr_dat_o         (spr_dat_o)
   );

endmodule

// ==== test/immu_tb_model.svh ====
/*
 * Reference model of the ITLB, included inside the testbench module.
 * Needs NUM_WAYS and SET_WIDTH declared before the include.
 * Words are kept exactly as written over SPR, reserved bits too.
 */
`ifndef IMMU_TB_MODEL_SVH
`define IMMU_TB_MODEL_SVH

localparam int PAGE_OFF = 13;

// Field positions in the match and translate words
localparam int MR_VALID = 0;
localparam int TR_CI    = 1;
localparam int TR_SXE   = 6;
localparam int TR_UXE   = 7;

logic [31:0] model_match [NUM_WAYS][2 ** SET_WIDTH];
logic [31:0] model_trans [NUM_WAYS][2 ** SET_WIDTH];

// Group 2, bit 9 set keeps clear of the control registers
function automatic logic [15:0] entry_addr(input int way, input int set, input bit trans);
   logic [15:0] a;
   a     = 16'h1200;
   a[10] = way[1];
   a[8]  = way[0];
   a[7]  = trans;
   a[SET_WIDTH-1:0] = set[SET_WIDTH-1:0];
   return a;
endfunction

function automatic void model_write(input int way, input int set, input bit trans,
                                    input logic [31:0] data);
   if (trans) begin
      model_trans[way][set] = data;
   end else begin
      model_match[way][set] = data;
   end
endfunction

function automatic logic [31:0] model_read(input int way, input int set, input bit trans);
   return trans ? model_trans[way][set] : model_match[way][set];
endfunction

function automatic void model_lookup(
   input  logic [31:0] va,
   input  logic        sup,
   output logic [31:0] phys,
   output logic        ci,
   output logic        miss,
   output logic        pf
);
   int          set;
   int          hit_way;
   logic [31:0] mw;
   logic [31:0] tw;
   set     = int'(va[PAGE_OFF +: SET_WIDTH]);
   hit_way = -1;
   for (int w = 0; w < NUM_WAYS; w++) begin
      mw = model_match[w][set];
      if (mw[MR_VALID] && mw[31:PAGE_OFF] == va[31:PAGE_OFF]) begin
         hit_way = w;
      end
   end
   if (hit_way < 0) begin
      // Zero page number, no permission at all
      phys = 32'(va[PAGE_OFF-1:0]);
      ci   = 1'b0;
      miss = 1'b1;
      pf   = 1'b1;
   end else begin
      tw   = model_trans[hit_way][set];
      phys = {tw[31:PAGE_OFF], va[PAGE_OFF-1:0]};
      ci   = tw[TR_CI];
      miss = 1'b0;
      pf   = sup ? ~tw[TR_SXE] : ~tw[TR_UXE];
   end
endfunction

`endif

// ==== test/immu_tb.sv ====
/*
 * Testbench of the ITLB top level, two ways of 64 sets.
 * Random stimulus from a Galois LFSR with a fixed seed.
 */
module immu_tb;
   localparam int NUM_WAYS   = 2;
   localparam int SET_WIDTH  = 6;
   localparam int SETS       = 2 ** SET_WIDTH;
   localparam int CLK_PERIOD = 100;
   localparam int ACK_WAIT   = 8;
   localparam int N_LOOKUP   = 64;
   // Writes and reads of all entries, three lookup runs, short tests
   localparam int NUM_OPS    = 4 * NUM_WAYS * SETS + 3 * N_LOOKUP + 16;
   localparam longint TIMEOUT = longint'(NUM_OPS) * 8 * CLK_PERIOD + 100 * CLK_PERIOD;

   logic        clk;
   logic        rst;
   logic        enable_i;
   logic [31:0] virt_addr_i;
   logic [31:0] virt_addr_match_i;
   logic        supervisor_mode_i;
   logic [15:0] spr_addr_i;
   logic        spr_we_i;
   logic        spr_stb_i;
   logic [31:0] spr_dat_i;
   logic [31:0] spr_dat_o;
   logic        spr_ack_o;
   logic [31:0] phys_addr_o;
   logic        cache_inhibit_o;
   logic        tlb_miss_o;
   logic        pagefault_o;
   logic        busy_o;

   int          errors;
   int          checks;
   int          tests_run;
   int          tests_failed;
   int          err_mark;
   logic [31:0] lfsr_state;

   `include "immu_tb_model.svh"

   immu_top #(
      .NUM_WAYS  (NUM_WAYS),
      .SET_WIDTH (SET_WIDTH)
   ) dut (
      .clk               (clk),
      .rst               (rst),
      .enable_i          (enable_i),
      .virt_addr_i       (virt_addr_i),
      .virt_addr_match_i (virt_addr_match_i),
      .supervisor_mode_i (supervisor_mode_i),
      .spr_addr_i        (spr_addr_i),
      .spr_we_i          (spr_we_i),
      .spr_stb_i         (spr_stb_i),
      .spr_dat_i         (spr_dat_i),
      .spr_dat_o         (spr_dat_o),
      .spr_ack_o         (spr_ack_o),
      .phys_addr_o       (phys_addr_o),
      .cache_inhibit_o   (cache_inhibit_o),
      .tlb_miss_o        (tlb_miss_o),
      .pagefault_o       (pagefault_o),
      .busy_o            (busy_o)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   initial begin
      #(TIMEOUT);
      $display("Watchdog expired after %0d time units, run did not finish", TIMEOUT);
      $display("=== FAIL ===");
      $finish;
   end

   // Galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("[ERROR] %s: expected %h, got %h", name, exp, got);
         errors++;
      end
   endtask

   task automatic check_ack(input bit acked, input logic [15:0] addr);
      checks++;
      assert (acked) else begin
         $display("SPR access to address %h was never acknowledged", addr);
         errors++;
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors > err_mark) begin
         tests_failed++;
      end
      $display("test %s: %s (%0d errors)", name, (errors > err_mark) ? "failed" : "ok",
               errors - err_mark);
      err_mark = errors;
   endtask

   // Counts busy cycles, lookup flags must be masked meanwhile
   task automatic note_busy(inout int busy_cycles);
      if (busy_o === 1'b1) begin
         busy_cycles++;
         check_val("tlb_miss_o", tlb_miss_o, 0);
         check_val("pagefault_o", pagefault_o, 0);
      end
   endtask

   task automatic spr_access(input logic [15:0] addr, input bit we, input logic [31:0] wdata,
                             output logic [31:0] rdata, output int busy_cycles,
                             output bit acked);
      int waited;
      acked       = 1'b0;
      busy_cycles = 0;
      waited      = 0;
      rdata       = '0;
      @(posedge clk);
      spr_addr_i <= addr;
      spr_we_i   <= we;
      spr_dat_i  <= wdata;
      spr_stb_i  <= 1'b1;
      while (!acked && waited < ACK_WAIT) begin
         @(negedge clk);
         note_busy(busy_cycles);
         if (spr_ack_o === 1'b1) begin
            acked = 1'b1;
            rdata = spr_dat_o;
         end
         waited++;
      end
      // Strobe stays one more cycle so ack and read data must hold
      if (acked) begin
         @(negedge clk);
         note_busy(busy_cycles);
         check_val("spr_ack_o", spr_ack_o, 1);
         if (!we) begin
            check_val("spr_dat_o", spr_dat_o, rdata);
         end
      end
      @(posedge clk);
      spr_stb_i <= 1'b0;
      spr_we_i  <= 1'b0;
      // Two idle cycles also catch a busy window that runs long
      repeat (2) begin
         @(negedge clk);
         note_busy(busy_cycles);
      end
   endtask

   task automatic expect_no_ack(input logic [15:0] addr, input bit we);
      @(posedge clk);
      spr_addr_i <= addr;
      spr_we_i   <= we;
      spr_dat_i  <= rand_bits(32);
      spr_stb_i  <= 1'b1;
      repeat (ACK_WAIT) begin
         @(negedge clk);
         check_val("spr_ack_o", spr_ack_o, 0);
      end
      @(posedge clk);
      spr_stb_i <= 1'b0;
      spr_we_i  <= 1'b0;
   endtask

   task automatic lookup_check(input logic [31:0] va, input logic sup);
      logic [31:0] e_phys;
      logic        e_ci;
      logic        e_miss;
      logic        e_pf;
      @(posedge clk);
      virt_addr_i <= va;
      @(posedge clk);
      virt_addr_match_i <= va;
      supervisor_mode_i <= sup;
      @(negedge clk);
      model_lookup(va, sup, e_phys, e_ci, e_miss, e_pf);
      check_val("phys_addr_o", phys_addr_o, e_phys);
      check_val("cache_inhibit_o", cache_inhibit_o, e_ci);
      check_val("tlb_miss_o", tlb_miss_o, e_miss);
      check_val("pagefault_o", pagefault_o, e_pf);
   endtask

   task automatic write_readback();
      logic [31:0] mw;
      logic [31:0] rd;
      int          bc;
      bit          ack;
      for (int w = 0; w < NUM_WAYS; w++) begin
         for (int s = 0; s < SETS; s++) begin
            // VPN low bits follow the set, one bit tells the ways apart
            mw = {12'(rand_bits(12)), w[0], 6'(s), 12'(rand_bits(12)), |rand_bits(2)};
            spr_access(entry_addr(w, s, 0), 1'b1, mw, rd, bc, ack);
            check_ack(ack, entry_addr(w, s, 0));
            model_write(w, s, 0, mw);
            mw = rand_bits(32);
            spr_access(entry_addr(w, s, 1), 1'b1, mw, rd, bc, ack);
            check_ack(ack, entry_addr(w, s, 1));
            model_write(w, s, 1, mw);
         end
      end
      for (int w = 0; w < NUM_WAYS; w++) begin
         for (int s = 0; s < SETS; s++) begin
            for (int t = 0; t < 2; t++) begin
               spr_access(entry_addr(w, s, t[0]), 1'b0, '0, rd, bc, ack);
               check_ack(ack, entry_addr(w, s, t[0]));
               check_val("spr_dat_o", rd, model_read(w, s, t[0]));
            end
         end
      end
   endtask

   task automatic run_lookups(input bit want_hit);
      int          w;
      int          s;
      int          tries;
      logic [18:0] vpn;
      repeat (N_LOOKUP) begin
         tries = 0;
         do begin
            w = int'(rand_bits(1));
            s = int'(rand_bits(SET_WIDTH));
            tries++;
         end while (model_match[w][s][MR_VALID] !== want_hit && tries < 16);
         vpn = model_match[w][s][31:PAGE_OFF];
         // Top VPN bit flipped cannot match in either way
         if (!want_hit && model_match[w][s][MR_VALID]) begin
            vpn[18] = ~vpn[18];
         end
         lookup_check({vpn, 13'(rand_bits(13))}, rand_bits(1) == 1);
      end
   endtask

   task automatic busy_window();
      logic [31:0] tw;
      logic [31:0] rd;
      int          bc;
      bit          ack;
      tw = rand_bits(32);
      spr_access(entry_addr(1, 5, 1), 1'b1, tw, rd, bc, ack);
      check_ack(ack, entry_addr(1, 5, 1));
      model_write(1, 5, 1, tw);
      check_val("busy_o high cycles", bc, 2);
      @(posedge clk);
      enable_i <= 1'b0;
      spr_access(entry_addr(0, 9, 0), 1'b0, '0, rd, bc, ack);
      check_ack(ack, entry_addr(0, 9, 0));
      check_val("busy_o high cycles", bc, 0);
      @(posedge clk);
      enable_i <= 1'b1;
   endtask

   task automatic group_ack();
      logic [4:0]  grp;
      logic [15:0] addr;
      logic [31:0] rd;
      int          bc;
      bit          ack;
      repeat (4) begin
         grp = 5'(rand_bits(5));
         if (grp == 5'd2) begin
            grp = 5'd3;
         end
         expect_no_ack({grp, 11'(rand_bits(11))}, rand_bits(1) == 1);
      end
      repeat (4) begin
         // Control and status space of group 2
         addr = {5'd2, 2'b00, 9'(rand_bits(9))};
         spr_access(addr, 1'b1, rand_bits(32), rd, bc, ack);
         check_ack(ack, addr);
         spr_access(addr, 1'b0, '0, rd, bc, ack);
         check_ack(ack, addr);
         check_val("spr_dat_o", rd, 0);
      end
   endtask

   initial begin
      clk               = 1'b0;
      rst               = 1'b1;
      enable_i          = 1'b1;
      virt_addr_i       = '0;
      virt_addr_match_i = '0;
      supervisor_mode_i = 1'b0;
      spr_addr_i        = '0;
      spr_we_i          = 1'b0;
      spr_stb_i         = 1'b0;
      spr_dat_i         = '0;
      lfsr_state        = 32'd32;
      errors            = 0;
      checks            = 0;
      tests_run         = 0;
      tests_failed      = 0;
      err_mark          = 0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      write_readback();
      finish_test("write and read back");
      run_lookups(1'b1);
      finish_test("translation hit");
      run_lookups(1'b0);
      finish_test("miss");
      run_lookups(1'b1);
      finish_test("page fault");
      busy_window();
      finish_test("busy window");
      group_ack();
      finish_test("acknowledge by group");

      $display("%0d tests run, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+test
hdl/immu_pkg.sv
hdl/immu_spr_decode.sv
hdl/immu_itlb_way.sv
hdl/immu_way_select.sv
hdl/immu_top.sv
test/immu_tb.sv

// ==== Bender.yml ====
package:
  name: immu_itlb

sources:
  - hdl/immu_pkg.sv
  - hdl/immu_spr_decode.sv
  - hdl/immu_itlb_way.sv
  - hdl/immu_way_select.sv
  - hdl/immu_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/immu_tb.sv
